// File: src/pipe_pkg.sv
/*
 * Shared definitions for the integer execution pipeline
 * Datapath widths, buffer depths, opcode and operand-select
 * encodings, and the packets that pass between the stages
 */
`default_nettype none

package pipe_pkg;

	// Datapath widths
	localparam int DATA_W = 32;
	localparam int REG_AW = 3;
	localparam int IMM_W  = 16;

	// Ingress depth doubles as the upstream's starting credit count
	localparam int INGRESS_DEPTH = 4;
	localparam int EGRESS_DEPTH  = 4;

	// Pointer and occupancy widths
	localparam int INGRESS_AW    = $clog2(INGRESS_DEPTH);
	localparam int INGRESS_CNT_W = $clog2(INGRESS_DEPTH + 1);
	localparam int EGRESS_AW     = $clog2(EGRESS_DEPTH);
	localparam int EGRESS_CNT_W  = $clog2(EGRESS_DEPTH + 1);

	// Output credit counter saturates at its top value
	localparam int CREDIT_W = 8;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_ADDI = 3'd5,
		OP_SLL  = 3'd6,
		OP_NOP  = 3'd7
	} opcode_t;

	// Operand source, immediate only on B
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} opsel_t;

	typedef struct packed {
		opcode_t           opcode;
		logic [REG_AW-1:0] rd;
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic [IMM_W-1:0]  imm;
	} instr_t;

	typedef struct packed {
		logic [REG_AW-1:0] rd;
		logic [DATA_W-1:0] value;
	} result_t;

	// Control bundle that rides with the operands into execute
	typedef struct packed {
		opcode_t           opcode;
		logic [REG_AW-1:0] rd;
		logic              valid;
	} exec_op_t;

endpackage

`default_nettype wire

// File: src/instr_ingress.sv
/*
 * Instruction ingress buffer
 * Circular FIFO fed by the credit-holding upstream
 * Every pop returns one credit through a registered pulse
 */
`default_nettype none

module instr_ingress (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  pipe_pkg::instr_t in_instr,
	output logic             in_credit,
	output logic             head_valid,
	output pipe_pkg::instr_t head_instr,
	input  logic             head_pop
);
	import pipe_pkg::*;

	instr_t                   mem [INGRESS_DEPTH];
	logic [INGRESS_AW-1:0]    wr_ptr;
	logic [INGRESS_AW-1:0]    rd_ptr;
	logic [INGRESS_CNT_W-1:0] count;
	logic                     full;
	logic                     wr_en;
	logic                     rd_en;

	assign full = (count == INGRESS_CNT_W'(INGRESS_DEPTH));
	// Write into a full buffer is lost
	assign wr_en = in_valid && !full;
	assign rd_en = head_pop && head_valid;

	// Head is visible the cycle after its write
	assign head_valid = (count != '0);
	assign head_instr = mem[rd_ptr];

	// Storage
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= in_instr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// Occupancy
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Freed slot goes back upstream
			in_credit <= rd_en;
		end
	end

endmodule

`default_nettype wire

// File: src/issue_ctrl.sv
/*
 * Issue control
 * Decodes the ingress head, reads source indexes, picks each
 * operand's source from the in-flight destinations, and stops
 * the pipeline when egress room runs short
 */
`default_nettype none

module issue_ctrl (
	input  logic                           head_valid,
	input  pipe_pkg::instr_t               head_instr,
	output logic                           head_pop,
	output logic [pipe_pkg::REG_AW-1:0]    rd_idx_a,
	output logic [pipe_pkg::REG_AW-1:0]    rd_idx_b,
	output pipe_pkg::opsel_t               sel_a,
	output pipe_pkg::opsel_t               sel_b,
	output logic [pipe_pkg::DATA_W-1:0]    imm_ext,
	output pipe_pkg::exec_op_t             id_op,
	input  logic [pipe_pkg::REG_AW-1:0]    ex_dest,
	input  logic [pipe_pkg::REG_AW-1:0]    wb_dest,
	input  logic                           ex_dest_valid,
	input  logic                           wb_valid,
	input  logic [pipe_pkg::EGRESS_CNT_W-1:0] egress_free,
	output logic                           freeze
);
	import pipe_pkg::*;

	logic [EGRESS_CNT_W-1:0] in_flight;

	// Newest producer wins, then writeback, then the register file
	function automatic opsel_t fwd_sel(
		input logic [REG_AW-1:0] src,
		input logic [REG_AW-1:0] ex_rd,
		input logic              ex_live,
		input logic [REG_AW-1:0] wb_rd,
		input logic              wb_live
	);
		opsel_t sel;
		if (ex_live && (ex_rd == src))
			sel = SEL_EX_FORW;
		else if (wb_live && (wb_rd == src))
			sel = SEL_WB_FORW;
		else
			sel = SEL_RF;
		return sel;
	endfunction

	//////////////////////////////////////////////////
	// Freeze from egress room
	//////////////////////////////////////////////////

	// Results still to be pushed ahead of the head
	assign in_flight = EGRESS_CNT_W'(ex_dest_valid) + EGRESS_CNT_W'(wb_valid);
	// Each in-flight result needs a slot before anything new moves
	assign freeze   = (egress_free <= in_flight);
	assign head_pop = head_valid && !freeze;

	//////////////////////////////////////////////////
	// Decode and operand select
	//////////////////////////////////////////////////

	assign rd_idx_a = head_instr.ra;
	assign rd_idx_b = head_instr.rb;

	assign imm_ext = {{(DATA_W - IMM_W){head_instr.imm[IMM_W-1]}}, head_instr.imm};

	always_comb begin
		sel_a = fwd_sel(head_instr.ra, ex_dest, ex_dest_valid, wb_dest, wb_valid);
		// ADDI takes its B operand from the immediate
		if (head_instr.opcode == OP_ADDI)
			sel_b = SEL_IMM;
		else
			sel_b = fwd_sel(head_instr.rb, ex_dest, ex_dest_valid, wb_dest, wb_valid);
	end

	// No pop means a bubble heads into execute
	always_comb begin
		id_op.opcode = head_instr.opcode;
		id_op.rd     = head_instr.rd;
		id_op.valid  = head_pop;
	end

endmodule

`default_nettype wire

// File: src/reg_file.sv
/*
 * Register file
 * Eight 32-bit registers, two asynchronous read ports
 * and one synchronous write port from writeback
 */
`default_nettype none

module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [pipe_pkg::REG_AW-1:0] rd_idx_a,
	input  logic [pipe_pkg::REG_AW-1:0] rd_idx_b,
	output logic [pipe_pkg::DATA_W-1:0] rf_data_a,
	output logic [pipe_pkg::DATA_W-1:0] rf_data_b,
	input  logic                        wr_en,
	input  logic [pipe_pkg::REG_AW-1:0] wr_idx,
	input  logic [pipe_pkg::DATA_W-1:0] wr_data
);
	import pipe_pkg::*;

	localparam int NUM_REGS = 2 ** REG_AW;

	logic [DATA_W-1:0] regs [NUM_REGS];

	// Architectural state starts at zero, register 0 included
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Reads see a write from the following cycle on
	assign rf_data_a = regs[rd_idx_a];
	assign rf_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// File: src/operand_mux.sv
/*
 * Operand stage
 * Forwarding muxes for both operands and the operand
 * registers that feed execute, held while frozen
 */
`default_nettype none

module operand_mux (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        freeze,
	input  logic [pipe_pkg::DATA_W-1:0] rf_data_a,
	input  logic [pipe_pkg::DATA_W-1:0] rf_data_b,
	input  logic [pipe_pkg::DATA_W-1:0] imm_ext,
	input  logic [pipe_pkg::DATA_W-1:0] ex_forw,
	input  logic [pipe_pkg::DATA_W-1:0] wb_forw,
	input  pipe_pkg::opsel_t            sel_a,
	input  pipe_pkg::opsel_t            sel_b,
	input  pipe_pkg::exec_op_t          id_op,
	output logic [pipe_pkg::DATA_W-1:0] operand_a,
	output logic [pipe_pkg::DATA_W-1:0] operand_b,
	output pipe_pkg::exec_op_t          ex_op
);
	import pipe_pkg::*;

	logic [DATA_W-1:0] muxed_a;
	logic [DATA_W-1:0] muxed_b;

	// Operand A, immediate not selectable
	always_comb begin
		case (sel_a)
			SEL_EX_FORW: muxed_a = ex_forw;
			SEL_WB_FORW: muxed_a = wb_forw;
			default:     muxed_a = rf_data_a;
		endcase
	end

	// Operand B
	always_comb begin
		case (sel_b)
			SEL_IMM:     muxed_b = imm_ext;
			SEL_EX_FORW: muxed_b = ex_forw;
			SEL_WB_FORW: muxed_b = wb_forw;
			default:     muxed_b = rf_data_b;
		endcase
	end

	// Operand values
	always_ff @(posedge clk) begin
		if (!freeze) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
		end
	end

	// Control follows the same hold
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_op <= '0;
		else if (!freeze)
			ex_op <= id_op;
	end

endmodule

`default_nettype wire

// File: src/exec_unit.sv
/*
 * Execute stage
 * Opcode-driven ALU on the registered operands, and the
 * writeback register behind it
 */
`default_nettype none

module exec_unit (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        freeze,
	input  logic [pipe_pkg::DATA_W-1:0] operand_a,
	input  logic [pipe_pkg::DATA_W-1:0] operand_b,
	input  pipe_pkg::exec_op_t          ex_op,
	output logic [pipe_pkg::DATA_W-1:0] ex_forw,
	output logic [pipe_pkg::REG_AW-1:0] ex_dest,
	output logic                        ex_dest_valid,
	output logic [pipe_pkg::DATA_W-1:0] wb_forw,
	output logic [pipe_pkg::REG_AW-1:0] wb_dest,
	output logic                        wb_valid
);
	import pipe_pkg::*;

	logic [DATA_W-1:0] alu_res;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////

	always_comb begin
		case (ex_op.opcode)
			OP_ADD:  alu_res = operand_a + operand_b;
			OP_SUB:  alu_res = operand_a - operand_b;
			OP_AND:  alu_res = operand_a & operand_b;
			OP_OR:   alu_res = operand_a | operand_b;
			OP_XOR:  alu_res = operand_a ^ operand_b;
			// B already holds the sign-extended immediate
			OP_ADDI: alu_res = operand_a + operand_b;
			OP_SLL:  alu_res = operand_a << operand_b[4:0];
			default: alu_res = '0;
		endcase
	end

	// Live result for forwarding, NOP has no destination
	assign ex_forw       = alu_res;
	assign ex_dest       = ex_op.rd;
	assign ex_dest_valid = ex_op.valid && (ex_op.opcode != OP_NOP);

	//////////////////////////////////////////////////
	// Writeback register
	//////////////////////////////////////////////////

	// Payload holds across a freeze
	always_ff @(posedge clk) begin
		if (!freeze) begin
			wb_forw <= alu_res;
			wb_dest <= ex_op.rd;
		end
	end

	// Writeback pushes once and then drains while execute is held
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_valid <= 1'b0;
		else if (freeze)
			wb_valid <= 1'b0;
		else
			wb_valid <= ex_dest_valid;
	end

endmodule

`default_nettype wire

// File: src/result_egress.sv
/*
 * Result egress buffer
 * FIFO of results with a credit counter from the consumer
 * One registered out_valid pulse per result, only with credit
 */
`default_nettype none

module result_egress (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              push,
	input  pipe_pkg::result_t                 push_result,
	output logic [pipe_pkg::EGRESS_CNT_W-1:0] egress_free,
	input  logic                              out_credit,
	output logic                              out_valid,
	output pipe_pkg::result_t                 out_result
);
	import pipe_pkg::*;

	result_t                 mem [EGRESS_DEPTH];
	logic [EGRESS_AW-1:0]    wr_ptr;
	logic [EGRESS_AW-1:0]    rd_ptr;
	logic [EGRESS_CNT_W-1:0] count;
	logic [CREDIT_W-1:0]     credit;
	logic                    wr_en;
	logic                    send;

	assign egress_free = EGRESS_CNT_W'(EGRESS_DEPTH) - count;
	assign wr_en       = push && (egress_free != '0);
	// Send needs a stored result and a granted slot
	assign send        = (count != '0) && (credit != '0);

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= push_result;
		if (send)
			out_result <= mem[rd_ptr];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credit    <= '0;
			out_valid <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (send)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + EGRESS_CNT_W'(wr_en) - EGRESS_CNT_W'(send);
			// Credit in, credit out, saturate at the top
			if (out_credit && !send && (credit != '1))
				credit <= credit + 1'b1;
			else if (!out_credit && send)
				credit <= credit - 1'b1;
			out_valid <= send;
		end
	end

endmodule

`default_nettype wire

// File: src/alu_core_top.sv
/*
 * Integer execution pipeline top level
 * Ingress buffer, issue and register file, operand stage,
 * execute and writeback, then the egress buffer
 */
`default_nettype none

module alu_core_top (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  pipe_pkg::instr_t  in_instr,
	output logic              in_credit,
	input  logic              out_credit,
	output logic              out_valid,
	output pipe_pkg::result_t out_result
);
	import pipe_pkg::*;

	// Ingress to issue
	logic                    head_valid;
	instr_t                  head_instr;
	logic                    head_pop;
	// Issue to register file and operand stage
	logic [REG_AW-1:0]       rd_idx_a;
	logic [REG_AW-1:0]       rd_idx_b;
	logic [DATA_W-1:0]       rf_data_a;
	logic [DATA_W-1:0]       rf_data_b;
	opsel_t                  sel_a;
	opsel_t                  sel_b;
	logic [DATA_W-1:0]       imm_ext;
	exec_op_t                id_op;
	logic                    freeze;
	// Operand stage to execute
	logic [DATA_W-1:0]       operand_a;
	logic [DATA_W-1:0]       operand_b;
	exec_op_t                ex_op;
	// Execute and writeback feedback
	logic [DATA_W-1:0]       ex_forw;
	logic [REG_AW-1:0]       ex_dest;
	logic                    ex_dest_valid;
	logic [DATA_W-1:0]       wb_forw;
	logic [REG_AW-1:0]       wb_dest;
	logic                    wb_valid;
	logic [EGRESS_CNT_W-1:0] egress_free;

	//////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////

	instr_ingress u_instr_ingress (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.head_valid (head_valid),
		.head_instr (head_instr),
		.head_pop   (head_pop)
	);

	//////////////////////////////////////////////////
	// Processing part
	//////////////////////////////////////////////////

	issue_ctrl u_issue_ctrl (
		.head_valid    (head_valid),
		.head_instr    (head_instr),
		.head_pop      (head_pop),
		.rd_idx_a      (rd_idx_a),
		.rd_idx_b      (rd_idx_b),
		.sel_a         (sel_a),
		.sel_b         (sel_b),
		.imm_ext       (imm_ext),
		.id_op         (id_op),
		.ex_dest       (ex_dest),
		.wb_dest       (wb_dest),
		.ex_dest_valid (ex_dest_valid),
		.wb_valid      (wb_valid),
		.egress_free   (egress_free),
		.freeze        (freeze)
	);

	// Writeback doubles as the write port
	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.wr_en     (wb_valid),
		.wr_idx    (wb_dest),
		.wr_data   (wb_forw)
	);

	operand_mux u_operand_mux (
		.clk       (clk),
		.rst_n     (rst_n),
		.freeze    (freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.imm_ext   (imm_ext),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_forw),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.id_op     (id_op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_op     (ex_op)
	);

	exec_unit u_exec_unit (
		.clk           (clk),
		.rst_n         (rst_n),
		.freeze        (freeze),
		.operand_a     (operand_a),
		.operand_b     (operand_b),
		.ex_op         (ex_op),
		.ex_forw       (ex_forw),
		.ex_dest       (ex_dest),
		.ex_dest_valid (ex_dest_valid),
		.wb_forw       (wb_forw),
		.wb_dest       (wb_dest),
		.wb_valid      (wb_valid)
	);

	//////////////////////////////////////////////////
	// Output side
	//////////////////////////////////////////////////

	// Result packet is rd followed by value
	result_egress u_result_egress (
		.clk         (clk),
		.rst_n       (rst_n),
		.push        (wb_valid),
		.push_result ({wb_dest, wb_forw}),
		.egress_free (egress_free),
		.out_credit  (out_credit),
		.out_valid   (out_valid),
		.out_result  (out_result)
	);

endmodule

`default_nettype wire

// File: tests/alu_core_chk.sv
/*
 * Protocol checker for the pipeline top level
 * Credit rules on the input and output side, freeze
 * behavior, and quiet outputs after reset
 */
`default_nettype none

module alu_core_chk (
	input logic                              clk,
	input logic                              rst_n,
	input logic                              in_valid,
	input logic                              in_credit,
	input logic                              out_credit,
	input logic                              out_valid,
	input logic                              head_pop,
	input logic                              wb_valid,
	input logic [pipe_pkg::EGRESS_CNT_W-1:0] egress_free
);
	timeunit 1ns;
	timeprecision 100ps;
	import pipe_pkg::*;

	int unsigned fail_count;
	// Ingress occupancy from accepted writes and head pops
	logic [3:0]  ing_count;
	logic        ing_full;
	// Output credits granted and not yet used
	logic [15:0] out_bal;
	logic [15:0] out_avail;
	logic        seen_input;

	initial fail_count = 0;

	assign ing_full  = (ing_count == 4'(INGRESS_DEPTH));
	assign out_avail = out_bal + 16'(out_credit);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ing_count  <= '0;
			out_bal    <= '0;
			seen_input <= 1'b0;
		end else begin
			ing_count <= ing_count + 4'(in_valid && !ing_full) - 4'(head_pop);
			out_bal   <= out_avail - 16'(out_valid);
			if (in_valid)
				seen_input <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Credit rules
	//////////////////////////////////////////////////

	// Write into a full ingress
	a_in_credit: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !ing_full)
	else begin
		fail_count++;
		$error("ingress written while all its slots were taken");
	end

	a_out_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (out_avail != '0))
	else begin
		fail_count++;
		$error("result sent beyond the granted output credits");
	end

	// Nothing leaves or returns before the first instruction
	a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_input |-> (!out_valid && !in_credit))
	else begin
		fail_count++;
		$error("output activity before any instruction was sent");
	end

	//////////////////////////////////////////////////
	// Freeze rules
	//////////////////////////////////////////////////

	a_egress_room: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (egress_free != '0))
	else begin
		fail_count++;
		$error("writeback pushed into a full egress buffer");
	end

endmodule

bind alu_core_top alu_core_chk u_alu_core_chk (.*);

`default_nettype wire

// File: tests/alu_core_tb.sv
/*
 * Testbench for the integer execution pipeline
 * Random credit-driven instruction stream checked against a
 * sequential register model, with long output stalls and a drain
 */
`default_nettype none

module alu_core_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import pipe_pkg::*;

	localparam int PHASE_SENDS   = 160;
	localparam int PHASE_LIMIT   = 6000;
	localparam int DRAIN_LIMIT   = 2000;
	localparam int SETTLE_CYCLES = 24;

	logic    clk;
	logic    rst_n;
	logic    in_valid;
	instr_t  in_instr;
	logic    in_credit;
	logic    out_credit;
	logic    out_valid;
	result_t out_result;

	// Register model, written in issue order
	logic [DATA_W-1:0] model_regs [8];
	result_t           expected_q [$];
	// Last two destinations, for distance 1 and 2 dependencies
	logic [REG_AW-1:0] recent_rd [2];

	int up_credits;
	int sent_count;
	int nop_count;
	int credit_pulses;
	int granted;
	int received;
	int mismatch_errors;
	int credit_errors;
	int other_errors;
	int assert_errors;

	alu_core_top u_alu_core_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_result (out_result)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Sequential result of one instruction
	function automatic logic [DATA_W-1:0] model_value(input instr_t ins);
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] imm_sx;
		a      = model_regs[ins.ra];
		b      = model_regs[ins.rb];
		imm_sx = DATA_W'($signed(ins.imm));
		case (ins.opcode)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_ADDI: return a + imm_sx;
			OP_SLL:  return a << b[4:0];
			default: return '0;
		endcase
	endfunction

	// Source index, biased toward recent producers
	function automatic logic [REG_AW-1:0] pick_src();
		int roll;
		roll = $urandom_range(9);
		if (roll < 3)
			return recent_rd[0];
		else if (roll < 5)
			return recent_rd[1];
		else
			return REG_AW'($urandom_range(7));
	endfunction

	function automatic instr_t make_instr();
		instr_t ins;
		ins.opcode = opcode_t'(3'($urandom_range(7)));
		ins.rd     = REG_AW'($urandom_range(7));
		ins.ra     = pick_src();
		ins.rb     = pick_src();
		ins.imm    = IMM_W'($urandom);
		return ins;
	endfunction

	task automatic check_result(input result_t got, input result_t exp);
		if (got !== exp) begin
			mismatch_errors++;
			$display("mismatch at %0t: got rd %0d value %h, expected rd %0d value %h",
				$time, got.rd, got.value, exp.rd, exp.value);
		end
	endtask

	task automatic check_credit_total(input integer got, input integer exp, input string what);
		if (got !== exp) begin
			credit_errors++;
			$display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// One instruction out, model updated at issue
	task automatic send_instr();
		instr_t  ins;
		result_t exp_r;
		ins      = make_instr();
		in_valid = 1'b1;
		in_instr = ins;
		up_credits--;
		sent_count++;
		if (ins.opcode == OP_NOP) begin
			nop_count++;
		end else begin
			exp_r.rd           = ins.rd;
			exp_r.value        = model_value(ins);
			model_regs[ins.rd] = exp_r.value;
			expected_q.push_back(exp_r);
			recent_rd[1] = recent_rd[0];
			recent_rd[0] = ins.rd;
		end
	endtask

	task automatic take_result();
		result_t exp_r;
		received++;
		if (expected_q.size() == 0) begin
			other_errors++;
			$display("result for rd %0d arrived at %0t with nothing left to match",
				out_result.rd, $time);
		end else begin
			exp_r = expected_q.pop_front();
			check_result(out_result, exp_r);
		end
	endtask

	// Sample on the falling edge, then drive the next inputs
	task automatic cycle_step(input bit may_send, input int credit_pct);
		@(negedge clk);
		if (in_credit) begin
			credit_pulses++;
			up_credits++;
		end
		if (up_credits > INGRESS_DEPTH) begin
			credit_errors++;
			$display("upstream holds more credits than ingress slots at %0t", $time);
		end
		if (out_valid)
			take_result();
		in_valid = 1'b0;
		if (may_send && (up_credits > 0) && ($urandom_range(99) < 70))
			send_instr();
		out_credit = ($urandom_range(99) < credit_pct);
		if (out_credit)
			granted++;
	endtask

	// Bursty mode withholds output credit for long stretches
	task automatic run_sends(input int target, input bit bursty);
		int spent;
		int pct;
		spent = 0;
		while ((sent_count < target) && (spent < PHASE_LIMIT)) begin
			if (bursty)
				pct = (((spent / 48) % 2) == 0) ? 0 : 35;
			else
				pct = 75;
			cycle_step(1'b1, pct);
			spent++;
		end
		if (sent_count < target) begin
			other_errors++;
			$display("timeout while sending, %0d of %0d instructions sent", sent_count, target);
		end
	endtask

	function automatic bit all_drained();
		return (received >= sent_count - nop_count) && (up_credits == INGRESS_DEPTH);
	endfunction

	task automatic drain();
		int spent;
		spent = 0;
		while (!all_drained() && (spent < DRAIN_LIMIT)) begin
			cycle_step(1'b0, 60);
			spent++;
		end
		if (!all_drained()) begin
			other_errors++;
			$display("timeout while draining, %0d results and %0d credits outstanding",
				sent_count - nop_count - received, INGRESS_DEPTH - up_credits);
		end
	endtask

	initial begin
		void'($urandom(32'he900));
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_instr   = '0;
		out_credit = 1'b0;
		up_credits = INGRESS_DEPTH;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		recent_rd[0] = '0;
		recent_rd[1] = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// Steady credit, then long stalls
		run_sends(PHASE_SENDS, 1'b0);
		if (other_errors == 0)
			run_sends(2 * PHASE_SENDS, 1'b1);
		if (other_errors == 0)
			drain();
		// Quiet window catches duplicates
		repeat (SETTLE_CYCLES) cycle_step(1'b0, 60);

		check_credit_total(credit_pulses, sent_count, "in_credit pulses against sends");
		check_credit_total(received, sent_count - nop_count, "results against non-NOP sends");
		assert_errors = u_alu_core_top.u_alu_core_chk.fail_count;
		$display("sent %0d nop %0d received %0d granted %0d, errors: %0d %0d %0d %0d",
			sent_count, nop_count, received, granted,
			mismatch_errors, credit_errors, other_errors, assert_errors);
		if ((mismatch_errors + credit_errors + other_errors + assert_errors) == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
src/pipe_pkg.sv
src/instr_ingress.sv
src/issue_ctrl.sv
src/reg_file.sv
src/operand_mux.sv
src/exec_unit.sv
src/result_egress.sv
src/alu_core_top.sv
tests/alu_core_chk.sv
tests/alu_core_tb.sv

// File: Makefile
# Verilator build and run of the pipeline testbench

VERILATOR ?= verilator
TOP       ?= alu_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
